/* build.f */
dac_link_pkg.sv
lmfc_counter.sv
link_fsm.sv
dac_pattern_gen.sv
lane_framer.sv
dac_link_top.sv
dac_link_properties.sv
tb_dac_link.sv

/* dac_link_pkg.sv */
package dac_link_pkg;

  // **************************************************
  // Link and converter sizes
  // **************************************************

  // Four DAC channels, each delivering two 16-bit samples per device clock
  localparam int num_channels = 4;
  localparam int sample_bits = 16;
  localparam int samples_per_channel = 2;

  // Two lanes, four octets per lane on every beat
  localparam int num_lanes = 2;
  localparam int octets_per_beat = 4;

  // Local multiframe length in beats and the width of the beat index
  localparam int beats_per_multiframe = 8;
  localparam int beat_bits = $clog2(beats_per_multiframe);

  // The alignment sequence lasts this many multiframes
  localparam int ilas_multiframes = 4;
  localparam int ilas_cnt_bits = $clog2(ilas_multiframes);

  // Running sample count of the test pattern, wraps at 8 bits
  localparam int count_bits = 8;
  localparam logic [count_bits-1:0] count_step = count_bits'(samples_per_channel);

  // **************************************************
  // Control characters
  // **************************************************

  // K28.5 fills the lanes during code-group sync
  localparam logic [7:0] k28_5 = 8'hbc;
  // K28.0 opens the alignment sequence (/R/)
  localparam logic [7:0] k28_0 = 8'h1c;
  // K28.3 closes each alignment multiframe (/A/)
  localparam logic [7:0] k28_3 = 8'h7c;

  // Link phases, in the order the transmitter walks through them
  typedef enum logic [1:0] {
    link_cgs,
    link_ilas,
    link_data
  } link_state_t;

  // Test pattern selection
  typedef enum logic {
    pat_chan_count,
    pat_chan_nibble
  } pattern_mode_t;

  // One beat of DAC samples, indexed as smp[channel][sample]
  // Channel 0 sample 0 sits in the low 16 bits
  typedef struct packed {
    logic [num_channels-1:0][samples_per_channel-1:0][sample_bits-1:0] smp;
  } dac_beat_t;

  // One lane beat with octet 0 in the low byte and one K flag per octet
  typedef struct packed {
    logic [octets_per_beat*8-1:0] data;
    logic [octets_per_beat-1:0]   charisk;
  } lane_beat_t;

endpackage

/* dac_link_properties.sv */
`timescale 1ns/10ps

module dac_link_properties (
  input logic                                                   tx_device_clk,
  input logic                                                   rst_n,
  input logic                                                   sync,
  input logic                                                   link_up,
  input dac_link_pkg::link_state_t                              state,
  input dac_link_pkg::lane_beat_t [dac_link_pkg::num_lanes-1:0] lanes
);

  // Phase of the beat now on the lanes, one cycle behind the FSM
  dac_link_pkg::link_state_t lane_state;
  // Alignment beats and /A/ markers seen since the last code-group sync
  logic [5:0] ilas_beats;
  logic [2:0] a_marks;
  logic       lanes_cgs;
  logic       lanes_r;
  logic       lanes_a_ok;
  // Read by the testbench for its closing line
  int         fail_count = 0;

  // **************************************************
  // Lane decode
  // **************************************************

  always_comb begin
    lanes_cgs  = 1'b1;
    lanes_r    = 1'b1;
    lanes_a_ok = 1'b1;
    for (int k = 0; k < dac_link_pkg::num_lanes; k++) begin
      for (int p = 0; p < dac_link_pkg::octets_per_beat; p++) begin
        if ((lanes[k].data[8*p +: 8] != dac_link_pkg::k28_5) || !lanes[k].charisk[p]) begin
          lanes_cgs = 1'b0;
        end
      end
      // /R/ in octet 0 of every lane
      if ((lanes[k].data[7:0] != dac_link_pkg::k28_0) || !lanes[k].charisk[0]) begin
        lanes_r = 1'b0;
      end
      // A K flag on octet 3 may only mean /A/ here
      if (lanes[k].charisk[3] && (lanes[k].data[31:24] != dac_link_pkg::k28_3)) begin
        lanes_a_ok = 1'b0;
      end
    end
  end

  always_ff @(posedge tx_device_clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_state <= dac_link_pkg::link_cgs;
      ilas_beats <= '0;
      a_marks    <= '0;
    end else begin
      lane_state <= state;
      if (lane_state == dac_link_pkg::link_cgs) begin
        ilas_beats <= '0;
        a_marks    <= '0;
      end else if (lane_state == dac_link_pkg::link_ilas) begin
        ilas_beats <= ilas_beats + 1'b1;
        if (lanes[0].charisk[3]) begin
          a_marks <= a_marks + 1'b1;
        end
      end
    end
  end

  // **************************************************
  // Assertions
  // **************************************************

  // Sync low puts the FSM in code-group sync, the lanes follow one cycle on
  cgs_fill: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    !sync |-> ##2 lanes_cgs)
    else begin
      $error("Lanes are not all K28.5 while sync is low");
      fail_count++;
    end

  cgs_link_down: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    !sync |=> !link_up)
    else begin
      $error("link_up is high after sync went low");
      fail_count++;
    end

  // The beat right after the K28.5 fill opens the alignment sequence
  ilas_start: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    $past(lanes_cgs) && !lanes_cgs |-> lanes_r)
    else begin
      $error("First beat after code-group sync does not start with K28.0");
      fail_count++;
    end

  // /A/ lands on every eighth alignment beat and nowhere else
  ilas_marker: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    lane_state == dac_link_pkg::link_ilas |->
      lanes_a_ok && (lanes[0].charisk[3] == (ilas_beats[2:0] == 3'd7))
      && (lanes[1].charisk[3] == (ilas_beats[2:0] == 3'd7)))
    else begin
      $error("Multiframe end marker is wrong or misplaced in alignment");
      fail_count++;
    end

  ilas_length: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    $rose(link_up) |=> (ilas_beats == 6'd32) && (a_marks == 3'd4))
    else begin
      $error("Alignment sequence is not 32 beats with 4 markers");
      fail_count++;
    end

  data_no_k: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    link_up && $past(link_up) |-> (lanes[0].charisk == '0) && (lanes[1].charisk == '0))
    else begin
      $error("Control character flagged during user data");
      fail_count++;
    end

  drop_to_cgs: assert property (@(posedge tx_device_clk) disable iff (!rst_n)
    $fell(link_up) |=> lanes_cgs)
    else begin
      $error("Lanes did not return to K28.5 after the link went down");
      fail_count++;
    end

endmodule

bind dac_link_top dac_link_properties i_dac_link_properties (
  .tx_device_clk (tx_device_clk),
  .rst_n         (rst_n),
  .sync          (sync),
  .link_up       (link_up),
  .state         (state),
  .lanes         (lanes)
);

/* dac_link_top.sv */
`timescale 1ns/10ps

module dac_link_top (
  input  logic                                                   tx_device_clk,
  input  logic                                                   rst_n,
  input  logic                                                   sync,
  input  dac_link_pkg::pattern_mode_t                            mode,
  output dac_link_pkg::lane_beat_t [dac_link_pkg::num_lanes-1:0] lanes,
  output logic                                                   link_up
);

  // Multiframe position shared by the FSM and the framer
  logic [dac_link_pkg::beat_bits-1:0] beat;
  logic                               lmfc_end;

  // Link phase and the sample beat it steers
  dac_link_pkg::link_state_t state;
  dac_link_pkg::dac_beat_t   samples;

  lmfc_counter i_lmfc_counter (
    .tx_device_clk (tx_device_clk),
    .rst_n         (rst_n),
    .beat          (beat),
    .lmfc_end      (lmfc_end)
  );

  link_fsm i_link_fsm (
    .tx_device_clk (tx_device_clk),
    .rst_n         (rst_n),
    .sync          (sync),
    .lmfc_end      (lmfc_end),
    .state         (state),
    .link_up       (link_up)
  );

  dac_pattern_gen i_dac_pattern_gen (
    .tx_device_clk (tx_device_clk),
    .rst_n         (rst_n),
    .state         (state),
    .mode          (mode),
    .samples       (samples)
  );

  lane_framer i_lane_framer (
    .tx_device_clk (tx_device_clk),
    .rst_n         (rst_n),
    .state         (state),
    .beat          (beat),
    .lmfc_end      (lmfc_end),
    .samples       (samples),
    .lanes         (lanes)
  );

endmodule

/* dac_pattern_gen.sv */
`timescale 1ns/10ps

module dac_pattern_gen (
  input  logic                        tx_device_clk,
  input  logic                        rst_n,
  input  dac_link_pkg::link_state_t   state,
  input  dac_link_pkg::pattern_mode_t mode,
  output dac_link_pkg::dac_beat_t     samples
);

  // Registered running count and the value the samples are built from
  logic [dac_link_pkg::count_bits-1:0] count_q;
  logic [dac_link_pkg::count_bits-1:0] count;
  logic                                in_data;

  assign in_data = (state == dac_link_pkg::link_data);

  // **************************************************
  // Running sample count
  // **************************************************

  // The count moves on by one beat of samples per clock in user data and
  // is cleared in every other phase, so each new link starts from zero
  always_ff @(posedge tx_device_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (in_data) begin
      count_q <= count_q + dac_link_pkg::count_step;
    end else begin
      count_q <= '0;
    end
  end

  // The register still holds the last data value in the first cycle after
  // sync is lost, hence the mask by phase
  assign count = in_data ? count_q : '0;

  // **************************************************
  // Sample builder
  // **************************************************

  always_comb begin : build_samples
    logic [dac_link_pkg::count_bits-1:0] low;
    samples = '0;
    for (int i = 0; i < dac_link_pkg::num_channels; i++) begin
      for (int j = 0; j < dac_link_pkg::samples_per_channel; j++) begin
        // Each sample in the beat is one step further along the count
        low = count + j[dac_link_pkg::count_bits-1:0];
        if (mode == dac_link_pkg::pat_chan_count) begin
          // Channel in the top nibble, bits 11 to 8 stay zero
          samples.smp[i][j][dac_link_pkg::sample_bits-1 -: 4]  = i[3:0];
          samples.smp[i][j][dac_link_pkg::count_bits-1:0]       = low;
        end else begin
          // Channel number repeated in every nibble
          samples.smp[i][j] = {(dac_link_pkg::sample_bits / 4){i[3:0]}};
        end
      end
    end
  end

endmodule

/* lane_framer.sv */
`timescale 1ns/10ps

module lane_framer (
  input  logic                                            tx_device_clk,
  input  logic                                            rst_n,
  input  dac_link_pkg::link_state_t                       state,
  input  logic [dac_link_pkg::beat_bits-1:0]              beat,
  input  logic                                            lmfc_end,
  input  dac_link_pkg::dac_beat_t                         samples,
  output dac_link_pkg::lane_beat_t [dac_link_pkg::num_lanes-1:0] lanes
);

  dac_link_pkg::lane_beat_t [dac_link_pkg::num_lanes-1:0] lanes_nxt;

  // **************************************************
  // Octet mapping per phase
  // **************************************************

  // A lane beat holds four octets, which is one channel's two samples.
  // Lane k serves channel 2k on even beats and channel 2k+1 on odd beats,
  // so the octets run ch 2k s0, ch 2k s1, ch 2k+1 s0, ch 2k+1 s1 over a
  // pair of beats, each sample low octet first

  always_comb begin : frame_lanes
    int         ch;
    logic [7:0] ilas_octet;
    lanes_nxt = '0;
    for (int k = 0; k < dac_link_pkg::num_lanes; k++) begin
      // Channel pair of this lane, picked by beat parity
      ch = k * (dac_link_pkg::num_channels / dac_link_pkg::num_lanes) + int'(beat[0]);
      case (state)
        dac_link_pkg::link_cgs: begin
          // Nothing but /K/ until the receiver raises sync
          for (int p = 0; p < dac_link_pkg::octets_per_beat; p++) begin
            lanes_nxt[k].data[8*p +: 8] = dac_link_pkg::k28_5;
            lanes_nxt[k].charisk[p]     = 1'b1;
          end
        end
        dac_link_pkg::link_ilas: begin
          for (int p = 0; p < dac_link_pkg::octets_per_beat; p++) begin
            // Ramp of the octet index within the multiframe
            ilas_octet = 8'(int'(beat) * dac_link_pkg::octets_per_beat + p);
            lanes_nxt[k].data[8*p +: 8] = ilas_octet;
            // /R/ starts the multiframe
            if ((p == 0) && (beat == '0)) begin
              lanes_nxt[k].data[8*p +: 8] = dac_link_pkg::k28_0;
              lanes_nxt[k].charisk[p]     = 1'b1;
            end
            // /A/ ends it
            if ((p == dac_link_pkg::octets_per_beat - 1) && lmfc_end) begin
              lanes_nxt[k].data[8*p +: 8] = dac_link_pkg::k28_3;
              lanes_nxt[k].charisk[p]     = 1'b1;
            end
          end
        end
        dac_link_pkg::link_data: begin
          // Sample 0 lands in the low half, charisk stays clear
          for (int j = 0; j < dac_link_pkg::samples_per_channel; j++) begin
            lanes_nxt[k].data[dac_link_pkg::sample_bits*j +: dac_link_pkg::sample_bits] =
              samples.smp[ch][j];
          end
        end
        default: begin
          lanes_nxt[k] = '0;
        end
      endcase
    end
  end

  // **************************************************
  // Output register
  // **************************************************

  // One cycle of latency from phase, beat and samples to the lanes
  always_ff @(posedge tx_device_clk or negedge rst_n) begin
    if (!rst_n) begin
      lanes <= '0;
    end else begin
      lanes <= lanes_nxt;
    end
  end

endmodule

/* link_fsm.sv */
`timescale 1ns/10ps

module link_fsm (
  input  logic                      tx_device_clk,
  input  logic                      rst_n,
  input  logic                      sync,
  input  logic                      lmfc_end,
  output dac_link_pkg::link_state_t state,
  output logic                      link_up
);

  dac_link_pkg::link_state_t state_nxt;

  // Completed alignment multiframes
  logic [dac_link_pkg::ilas_cnt_bits-1:0] mf_cnt;
  logic [dac_link_pkg::ilas_cnt_bits-1:0] mf_cnt_nxt;
  logic                                   ilas_last;

  // High during the final alignment multiframe
  assign ilas_last = (mf_cnt == dac_link_pkg::ilas_multiframes - 1);

  // **************************************************
  // Next state
  // **************************************************

  always_comb begin
    state_nxt  = state;
    mf_cnt_nxt = mf_cnt;
    case (state)
      dac_link_pkg::link_cgs: begin
        // The multiframe count starts from zero on every new alignment
        mf_cnt_nxt = '0;
        // Alignment may only begin on a multiframe boundary, so the first
        // alignment beat is beat 0
        if (sync && lmfc_end) begin
          state_nxt = dac_link_pkg::link_ilas;
        end
      end
      dac_link_pkg::link_ilas: begin
        if (!sync) begin
          state_nxt = dac_link_pkg::link_cgs;
        end else if (lmfc_end) begin
          // Four full multiframes, then user data from the next boundary
          if (ilas_last) begin
            state_nxt = dac_link_pkg::link_data;
          end else begin
            mf_cnt_nxt = mf_cnt + 1'b1;
          end
        end
      end
      dac_link_pkg::link_data: begin
        // The receiver drops sync to ask for a fresh code-group sync
        if (!sync) begin
          state_nxt = dac_link_pkg::link_cgs;
        end
      end
      default: begin
        state_nxt = dac_link_pkg::link_cgs;
      end
    endcase
  end

  // **************************************************
  // State registers
  // **************************************************

  always_ff @(posedge tx_device_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= dac_link_pkg::link_cgs;
      mf_cnt  <= '0;
      link_up <= 1'b0;
    end else begin
      state   <= state_nxt;
      mf_cnt  <= mf_cnt_nxt;
      // Taken from the next state so it tracks state without a cycle of lag
      link_up <= (state_nxt == dac_link_pkg::link_data);
    end
  end

endmodule

/* lmfc_counter.sv */
`timescale 1ns/10ps

module lmfc_counter (
  input  logic                               tx_device_clk,
  input  logic                               rst_n,
  output logic [dac_link_pkg::beat_bits-1:0] beat,
  output logic                               lmfc_end
);

  // **************************************************
  // Local multiframe clock
  // **************************************************

  // The beat index runs freely from reset and wraps at the end of every
  // local multiframe, so the alignment start and each /A/ marker that the
  // framer inserts line up with the multiframe boundary

  // Last beat of the multiframe, seen by the FSM and the framer alike
  assign lmfc_end = (beat == dac_link_pkg::beats_per_multiframe - 1);

  always_ff @(posedge tx_device_clk or negedge rst_n) begin
    if (!rst_n) begin
      beat <= '0;
    end else begin
      beat <= beat + 1'b1;
    end
  end

endmodule

/* tb_dac_link.sv */
`timescale 1ns/10ps

module tb_dac_link;

  // Worst case is about 290 cycles, the limit leaves some margin
  localparam int max_cycles = 400;

  logic                                                   tx_device_clk = 1'b0;
  logic                                                   rst_n;
  logic                                                   sync;
  dac_link_pkg::pattern_mode_t                            mode;
  dac_link_pkg::lane_beat_t [dac_link_pkg::num_lanes-1:0] lanes;
  logic                                                   link_up;

  string       test_name   = "reset";
  int          error_count = 0;
  int          cycle_count = 0;
  logic [31:0] rnd_state   = 32'd31727;

  // Checker state: data beats since link up, and the link and mode one cycle back
  int                          data_beats;
  logic                        up_seen;
  dac_link_pkg::pattern_mode_t mode_d;

  dac_link_top i_dut (
    .tx_device_clk (tx_device_clk),
    .rst_n         (rst_n),
    .sync          (sync),
    .mode          (mode),
    .lanes         (lanes),
    .link_up       (link_up)
  );

  always #20 tx_device_clk = ~tx_device_clk;

  // **************************************************
  // Helpers
  // **************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Sample of channel ch, index idx, for a beat whose running count is count
  function automatic logic [15:0] expected_sample(input dac_link_pkg::pattern_mode_t m,
                                                  input int ch, input int idx,
                                                  input logic [7:0] count);
    logic [3:0] c;
    logic [7:0] low;
    c   = ch[3:0];
    low = count + idx[7:0];
    if (m == dac_link_pkg::pat_chan_count) begin
      return {c, 4'h0, low};
    end else begin
      return {c, c, c, c};
    end
  endfunction

  // Lane k sends channel 2k on even data beats and channel 2k+1 on odd ones
  function automatic dac_link_pkg::lane_beat_t expected_lane(input dac_link_pkg::pattern_mode_t m,
                                                             input int k, input int n);
    dac_link_pkg::lane_beat_t w;
    int                       ch;
    logic [7:0]               count;
    ch        = 2 * k + (n % 2);
    count     = 8'(dac_link_pkg::samples_per_channel * n);
    w.data    = {expected_sample(m, ch, 1, count), expected_sample(m, ch, 0, count)};
    w.charisk = '0;
    return w;
  endfunction

  task automatic check_lanes(input dac_link_pkg::pattern_mode_t m, input int n);
    dac_link_pkg::lane_beat_t want;
    for (int k = 0; k < dac_link_pkg::num_lanes; k++) begin
      want = expected_lane(m, k, n);
      if (lanes[k] !== want) begin
        error_count++;
        $display("[ERROR] %s: lane %0d beat %0d expected %h actual %h",
                 test_name, k, n, want, lanes[k]);
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge tx_device_clk);
  endtask

  task automatic finish_run;
    int assert_fails;
    assert_fails = i_dut.i_dac_link_properties.fail_count;
    $display("Errors: %0d, assertion failures: %0d", error_count, assert_fails);
    if ((error_count == 0) && (assert_fails == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // **************************************************
  // Data checker and timeout
  // **************************************************

  // Lanes lag the link by a cycle, so a beat is checked once link_up was
  // already high at the previous sample
  always @(negedge tx_device_clk) begin
    if (!rst_n) begin
      data_beats = 0;
      up_seen    = 1'b0;
    end else begin
      if (up_seen) begin
        check_lanes(mode_d, data_beats);
        data_beats = data_beats + 1;
      end
      if (!link_up) begin
        data_beats = 0;
      end
      up_seen = link_up;
    end
    mode_d = mode;
  end

  always @(posedge tx_device_clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      error_count++;
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      finish_run();
    end
  end

  // **************************************************
  // Stimulus
  // **************************************************

  initial begin
    rst_n = 1'b0;
    sync  = 1'b0;
    mode  = dac_link_pkg::pat_chan_count;
    wait_cycles(2);
    rst_n <= 1'b1;
    test_name = "cgs";
    wait_cycles(20);
    test_name = "chan_count";
    sync <= 1'b1;
    wait_cycles(80);
    if (!link_up) begin
      error_count++;
      $display("Link did not come up within 80 cycles of sync rising");
    end
    test_name = "chan_nibble";
    mode <= dac_link_pkg::pat_chan_nibble;
    wait_cycles(40);
    // Drop sync, then raise it after a random delay so alignment starts at a new beat
    test_name = "realign";
    sync <= 1'b0;
    mode <= dac_link_pkg::pat_chan_count;
    rnd_state = xorshift32(rnd_state);
    wait_cycles(5 + int'(rnd_state % 8));
    sync <= 1'b1;
    while (!link_up) begin
      @(posedge tx_device_clk);
    end
    wait_cycles(60);
    finish_run();
  end

endmodule
